// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tuner_game_tb \
		-f files.f --Mdir obj_dir -o tuner_game_sim
	@out="$$(./obj_dir/tuner_game_sim)"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== files.f ====
hdl/pitch_pkg.sv
hdl/game_pkg.sv
hdl/period_meter.sv
hdl/note_classifier.sv
hdl/note_stabilizer.sv
hdl/game_fsm.sv
hdl/tuner_game_top.sv
verification/tuner_game_asserts.sv
verification/tuner_game_checker.sv
verification/tuner_game_tb.sv

// ==== hdl/game_fsm.sv ====
`timescale 1ns/100ps

module game_fsm #(
    parameter int song_length = 62
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  key,
    input  logic                  note_strobe,
    input  pitch_pkg::note_t      heard_note,
    output game_pkg::game_state_t state,
    output game_pkg::song_index_t note_index,
    output logic                  show_success,
    output logic                  show_failure
);

    import pitch_pkg::*;
    import game_pkg::*;

    localparam song_index_t last_index = song_index_t'(song_length - 1);

    logic key_sync;
    logic prev_key;
    logic key_pressed;

    //--------------------
    // Button edge

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_sync    <= 1'b0;
            prev_key    <= 1'b0;
            key_pressed <= 1'b0;
        end else begin
            key_sync    <= key;
            prev_key    <= key_sync;
            key_pressed <= key_sync & ~prev_key;
        end
    end

    //--------------------
    // Melody follower

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= idle;
            note_index   <= '0;
            show_success <= 1'b0;
            show_failure <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    show_success <= 1'b0;
                    show_failure <= 1'b0;
                    if (key_pressed) begin
                        state      <= playing;
                        note_index <= '0;
                    end
                end
                playing: begin
                    if (key_pressed) begin
                        state <= idle;
                    end else if (note_strobe) begin
                        if (heard_note == song[note_index]) begin
                            show_success <= 1'b1;
                            show_failure <= 1'b0;
                            if (note_index == last_index) begin
                                state <= win;
                            end else begin
                                note_index <= note_index + 1'b1;
                            end
                        end else begin
                            show_success <= 1'b0;
                            show_failure <= 1'b1;
                            state        <= fail;
                        end
                    end
                end
                fail: begin
                    note_index <= '0;
                    if (key_pressed) begin
                        state <= idle;
                    end
                end
                win: begin
                    if (key_pressed) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// ==== hdl/game_pkg.sv ====
package game_pkg;

    import pitch_pkg::*;

    typedef enum logic [1:0] {
        idle,
        playing,
        win,
        fail
    } game_state_t;

    localparam int max_song_length = 62;

    typedef logic [5:0] song_index_t;

    //--------------------
    // The melody, one phrase per line

    localparam note_t song [max_song_length] = '{
        e, g, d, c, d, e, g, d,
        e, g, d, c, g, f, e, d,
        e, g, d, c, d, e, g, d,
        e, g, d, c, g,
        g, f, e, f, e, c,
        f, e, d, e, d, a,
        g, f, e, f, e, c, f, c,
        e, g, d, c, d, e, g, d,
        e, g, d, c, g
    };

endpackage

// ==== hdl/note_classifier.sv ====
`timescale 1ns/100ps

module note_classifier #(
    parameter int clk_mhz = 50
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [pitch_pkg::w_period-1:0]  period,
    output pitch_pkg::note_t                note
);

    import pitch_pkg::*;

    note_t next_note;

    function automatic logic in_window(input int freq_100, input logic [w_period-1:0] p);
        int lo;
        int hi;
        lo = period_low(clk_mhz, freq_100);
        hi = period_high(clk_mhz, freq_100);
        return (int'(p) > lo) && (int'(p) < hi);
    endfunction

    //--------------------
    // Base octave and the two octaves above, lowest note wins

    always_comb begin
        next_note = no_note;
        for (int i = n_notes - 1; i >= 0; i--) begin
            if (in_window(freq_100_table[i], period) ||
                in_window(freq_100_table[i] * 2, period) ||
                in_window(freq_100_table[i] * 4, period)) begin
                next_note = note_t'(i + 1);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            note <= no_note;
        end else begin
            note <= next_note;
        end
    end

endmodule

// ==== hdl/note_stabilizer.sv ====
`timescale 1ns/100ps

module note_stabilizer #(
    parameter int hold_cycles = (1 << 20) - 1
) (
    input  logic              clk,
    input  logic              rst,
    input  pitch_pkg::note_t  note,
    output pitch_pkg::note_t  heard_note,
    output logic              note_strobe
);

    import pitch_pkg::*;

    localparam int w_hold = $clog2(hold_cycles + 1);
    localparam logic [w_hold-1:0] hold_last = w_hold'(hold_cycles - 1);
    localparam logic [w_hold-1:0] hold_full = w_hold'(hold_cycles);

    note_t             d_note;
    note_t             last_note;
    logic [w_hold-1:0] hold_cnt;
    logic              accept;

    // Counter reaches the hold time on this edge
    assign accept = (note == d_note) && (hold_cnt == hold_last);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_note      <= no_note;
            hold_cnt    <= '0;
            heard_note  <= no_note;
            last_note   <= no_note;
            note_strobe <= 1'b0;
        end else begin
            d_note      <= note;
            note_strobe <= 1'b0;

            if (note != d_note) begin
                hold_cnt <= '0;
            end else if (hold_cnt != hold_full) begin
                hold_cnt <= hold_cnt + 1'b1;
            end

            if (accept) begin
                if (d_note == no_note) begin
                    // Silence lets the same note be taken again
                    last_note <= no_note;
                end else begin
                    heard_note <= d_note;
                    if (d_note != last_note) begin
                        last_note   <= d_note;
                        note_strobe <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hdl/period_meter.sv ====
`timescale 1ns/100ps

module period_meter #(
    parameter int silence_cycles = (1 << 20) - 1
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic signed [23:0]              mic,
    output logic [pitch_pkg::w_period-1:0]  period
);

    import pitch_pkg::*;

    localparam logic [w_period-1:0] count_max = '1;

    logic                prev_sign;
    logic [w_period-1:0] counter;
    logic                crossing;

    // Negative sample followed by a non-negative one
    assign crossing = prev_sign & ~mic[$left(mic)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_sign <= 1'b0;
            counter   <= '0;
            period    <= '0;
        end else begin
            prev_sign <= mic[$left(mic)];
            if (crossing) begin
                period  <= counter;
                // The crossing cycle itself belongs to the next period
                counter <= w_period'(1);
            end else begin
                if (counter != count_max) begin
                    counter <= counter + 1'b1;
                end
                // No crossing for too long, the input is silent
                if (int'(counter) >= silence_cycles) begin
                    period <= '0;
                end
            end
        end
    end

endmodule

// ==== hdl/pitch_pkg.sv ====
package pitch_pkg;

    // Width of the zero-crossing period counter
    localparam int w_period = 20;

    localparam int n_notes = 12;

    typedef enum logic [3:0] {
        no_note,
        c,
        cs,
        d,
        ds,
        e,
        f,
        fs,
        g,
        gs,
        a,
        as,
        b
    } note_t;

    //--------------------
    // Measured note frequencies times 100, in note order from c to b

    localparam int freq_100_table [n_notes] = '{
        52325,
        55437,
        58733,
        62225,
        65926,
        69846,
        73999,
        78399,
        83061,
        88000,
        93233,
        98777
    };

    //--------------------
    // Period window bounds in clock cycles, 3 percent each side

    function automatic int period_low(input int clk_mhz, input int freq_100);
        return clk_mhz * 1000 * 1000 / freq_100 * 97;
    endfunction

    function automatic int period_high(input int clk_mhz, input int freq_100);
        return clk_mhz * 1000 * 1000 / freq_100 * 103;
    endfunction

endpackage

// ==== hdl/tuner_game_top.sv ====
`timescale 1ns/100ps

module tuner_game_top #(
    parameter int clk_mhz        = 50,
    parameter int silence_cycles = (1 << 20) - 1,
    parameter int hold_cycles    = (1 << 20) - 1,
    parameter int song_length    = 62
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic signed [23:0]    mic,
    input  logic                  key,
    output game_pkg::game_state_t state,
    output game_pkg::song_index_t note_index,
    output pitch_pkg::note_t      heard_note,
    output logic                  show_success,
    output logic                  show_failure
);

    import pitch_pkg::*;

    logic [w_period-1:0] period;
    note_t               note;
    logic                note_strobe;

    //--------------------
    // Pitch detection chain

    period_meter #(
        .silence_cycles (silence_cycles)
    ) period_meter_i (
        .clk    (clk),
        .rst    (rst),
        .mic    (mic),
        .period (period)
    );

    note_classifier #(
        .clk_mhz (clk_mhz)
    ) note_classifier_i (
        .clk    (clk),
        .rst    (rst),
        .period (period),
        .note   (note)
    );

    note_stabilizer #(
        .hold_cycles (hold_cycles)
    ) note_stabilizer_i (
        .clk         (clk),
        .rst         (rst),
        .note        (note),
        .heard_note  (heard_note),
        .note_strobe (note_strobe)
    );

    //--------------------
    // Game

    game_fsm #(
        .song_length (song_length)
    ) game_fsm_i (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .note_strobe  (note_strobe),
        .heard_note   (heard_note),
        .state        (state),
        .note_index   (note_index),
        .show_success (show_success),
        .show_failure (show_failure)
    );

endmodule

// ==== verification/tuner_game_asserts.sv ====
`timescale 1ns/100ps

module tuner_game_asserts #(
    parameter int song_length = 62
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  note_strobe,
    input game_pkg::game_state_t state,
    input game_pkg::song_index_t note_index,
    input logic                  show_success,
    input logic                  show_failure
);

    import game_pkg::*;

    // Read by the testbench for its closing count
    int failures;

    flags_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(show_success && show_failure)
    ) else begin
        $error("show_success and show_failure are high together");
        failures++;
    end

    fail_flag: assert property (
        @(posedge clk) disable iff (rst) (state == fail) |-> show_failure
    ) else begin
        $error("state is fail without show_failure");
        failures++;
    end

    // One strobe per accepted note
    strobe_single: assert property (
        @(posedge clk) disable iff (rst) note_strobe |=> !note_strobe
    ) else begin
        $error("note_strobe lasted more than one cycle");
        failures++;
    end

    index_range: assert property (
        @(posedge clk) disable iff (rst) int'(note_index) < song_length
    ) else begin
        $error("note_index is past the end of the song");
        failures++;
    end

endmodule

bind game_fsm tuner_game_asserts #(
    .song_length (song_length)
) asserts_i (
    .clk          (clk),
    .rst          (rst),
    .note_strobe  (note_strobe),
    .state        (state),
    .note_index   (note_index),
    .show_success (show_success),
    .show_failure (show_failure)
);

// ==== verification/tuner_game_checker.sv ====
`timescale 1ns/100ps

module tuner_game_checker (
    input  logic                  clk,
    input  logic                  check_valid,
    input  logic [8*24-1:0]       exp_name,
    input  logic [8*24-1:0]       exp_state,
    input  game_pkg::song_index_t exp_index,
    input  logic [8*24-1:0]       exp_heard,
    input  logic                  exp_success,
    input  logic                  exp_failure,
    input  game_pkg::game_state_t state,
    input  game_pkg::song_index_t note_index,
    input  pitch_pkg::note_t      heard_note,
    input  logic                  show_success,
    input  logic                  show_failure,
    output int                    checks,
    output int                    errors
);

    import pitch_pkg::*;
    import game_pkg::*;

    task automatic compare(input string what, input string expected, input string actual);
        if (expected != actual) begin
            $display("[FAIL] %0s: %0s expected %0s, actual %0s",
                     string'(exp_name), what, expected, actual);
            errors++;
        end
    endtask

    //--------------------
    // Outputs are read before the edge updates them

    always @(posedge clk) begin
        if (check_valid) begin
            checks++;
            compare("state", string'(exp_state), state.name());
            compare("note_index", $sformatf("%0d", exp_index),
                    $sformatf("%0d", note_index));
            compare("heard_note", string'(exp_heard), heard_note.name());
            compare("show_success", $sformatf("%0b", exp_success),
                    $sformatf("%0b", show_success));
            compare("show_failure", $sformatf("%0b", exp_failure),
                    $sformatf("%0b", show_failure));
        end
    end

endmodule

// ==== verification/tuner_game_tb.sv ====
`timescale 1ns/100ps

module tuner_game_tb;

    import pitch_pkg::*;
    import game_pkg::*;

    localparam int song_length = 8;
    localparam logic signed [23:0] level = 24'sd100000;

    logic               clk;
    logic               rst;
    logic signed [23:0] mic;
    logic               key;
    game_state_t        state;
    song_index_t        note_index;
    note_t              heard_note;
    logic               show_success;
    logic               show_failure;

    // Expected values handed to the checker
    logic               check_valid;
    logic [8*24-1:0]    exp_name;
    logic [8*24-1:0]    exp_state;
    song_index_t        exp_index;
    logic [8*24-1:0]    exp_heard;
    logic               exp_success;
    logic               exp_failure;
    int                 checks;
    int                 errors;

    bit first_pass;
    int file_errors;
    int assert_fails;
    int timed_cycles;
    int line_count;
    int cycle_limit;
    int cycle_count;

    tuner_game_top #(
        .clk_mhz        (1),
        .silence_cycles (4000),
        .hold_cycles    (300),
        .song_length    (song_length)
    ) dut_i (.*);

    tuner_game_checker checker_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout, the tests ran past %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //--------------------
    // Tone generation

    function automatic int tone_period(input note_t n, input int octave);
        if (n == no_note || octave < 1) begin
            return 0;
        end
        return 100 * (1000000 / (freq_100_table[int'(n) - 1] * octave));
    endfunction

    function automatic note_t note_from_name(input string name);
        note_t n;
        n = n.first();
        for (int i = 0; i < n.num(); i++) begin
            if (n.name() == name) begin
                return n;
            end
            n = n.next();
        end
        if (first_pass) begin
            $display("Unknown note name %0s in the tests file", name);
            file_errors++;
        end
        return no_note;
    endfunction

    // Square wave that starts with the positive half
    task automatic play_tone(input note_t n, input int octave, input int periods);
        int half;
        half = tone_period(n, octave) / 2;
        repeat (periods) begin
            mic = level;
            repeat (half) @(negedge clk);
            mic = -level;
            repeat (half) @(negedge clk);
        end
        mic = level;
    endtask

    //--------------------
    // Tests file

    task automatic run_line(input bit [8*128-1:0] text);
        bit [8*24-1:0] kind;
        bit [8*24-1:0] w1;
        bit [8*24-1:0] w2;
        bit [8*24-1:0] w3;
        int n1;
        int n2;
        int n3;
        if ($sscanf(text, "%s", kind) < 1 || kind == "#") begin
            return;
        end
        if (first_pass) begin
            line_count++;
        end
        case (kind)
            "tone": begin
                void'($sscanf(text, "%s %s %d %d", kind, w1, n1, n2));
                if (first_pass) begin
                    timed_cycles += n2 * tone_period(note_from_name(string'(w1)), n1);
                end else begin
                    play_tone(note_from_name(string'(w1)), n1, n2);
                end
            end
            "rest": begin
                void'($sscanf(text, "%s %d", kind, n1));
                if (first_pass) begin
                    timed_cycles += n1;
                end else begin
                    mic = level;
                    repeat (n1) @(negedge clk);
                end
            end
            "key": begin
                if (!first_pass) begin
                    key = 1'b1;
                    repeat (4) @(negedge clk);
                    key = 1'b0;
                    repeat (4) @(negedge clk);
                end
            end
            "expect": begin
                void'($sscanf(text, "%s %s %s %d %s %d %d", kind, w1, w2, n1, w3, n2, n3));
                if (!first_pass) begin
                    exp_name    = w1;
                    exp_state   = w2;
                    exp_index   = song_index_t'(n1);
                    exp_heard   = w3;
                    exp_success = n2[0];
                    exp_failure = n3[0];
                    check_valid = 1'b1;
                    @(negedge clk);
                    check_valid = 1'b0;
                end
            end
            default: begin
                if (first_pass) begin
                    $display("Unknown line kind %0s in the tests file", string'(kind));
                    file_errors++;
                end
            end
        endcase
    endtask

    task automatic read_tests();
        int fd;
        bit [8*128-1:0] text;
        fd = $fopen("verification/tuner_game_tests.txt", "r");
        if (fd == 0) begin
            if (first_pass) begin
                $display("Cannot open the tests file verification/tuner_game_tests.txt");
                file_errors++;
            end
        end else begin
            forever begin
                text = '0;
                if ($fgets(text, fd) == 0) begin
                    break;
                end
                run_line(text);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        mic         = level;
        key         = 1'b0;
        check_valid = 1'b0;
        exp_name    = '0;
        exp_state   = '0;
        exp_index   = '0;
        exp_heard   = '0;
        exp_success = 1'b0;
        exp_failure = 1'b0;

        // Size the run limit before any clock edge
        first_pass = 1'b1;
        read_tests();
        cycle_limit = timed_cycles + 100 * line_count + 1000;
        first_pass  = 1'b0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        read_tests();
        repeat (2) @(negedge clk);

        if (checks == 0) begin
            $display("No expect line was run, nothing was checked");
            file_errors++;
        end
        assert_fails = dut_i.game_fsm_i.asserts_i.failures;
        $display("Checks: %0d, compare errors: %0d, assertion failures: %0d, file errors: %0d",
                 checks, errors, assert_fails, file_errors);
        if (errors + assert_fails + file_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tuner_game_tests.txt ====
# tone <note> <octave 1/2/4> <periods>, rest <cycles>, key
# expect <name> <state> <note_index> <heard_note> <show_success> <show_failure>
rest 5000
expect after_reset idle 0 no_note 0 0
key
expect press_starts playing 0 no_note 0 0
tone e 1 4
rest 5000
expect song_note_0 playing 1 e 1 0
tone g 1 4
rest 5000
tone d 1 4
rest 5000
tone c 1 4
rest 5000
expect song_note_3 playing 4 c 1 0
tone d 1 4
rest 5000
tone e 1 4
rest 5000
tone g 1 4
rest 5000
tone d 1 4
rest 5000
expect song_win win 7 d 1 0
key
expect win_to_idle idle 7 d 0 0
key
expect restart playing 0 d 0 0
tone c 1 4
rest 5000
expect wrong_note fail 0 c 0 1
key
expect fail_to_idle idle 0 c 0 0
key
tone e 1 4
rest 5000
expect first_e playing 1 e 1 0
tone e 1 4
rest 5000
expect repeated_e fail 0 e 0 1
key
key
tone e 2 4
rest 5000
expect octave_e playing 1 e 1 0
tone g 1 1
rest 5000
expect short_tone playing 1 e 1 0
key
expect press_in_play idle 1 e 0 0
